//--- common/mem_shim_pkg.sv
//####################################################################
// Memory shim package
// Width constants, host request and response structs, user-side
// structs that carry a label in place of the tag, and the two bundles
// that run between the tracker, the host buffer and the host port
//####################################################################

package mem_shim_pkg;

    localparam int addr_bits = 16;
    localparam int data_bits = 32;
    // Sixteen tags per channel
    localparam int tag_bits  = 4;
    localparam int meta_bits = 16;

    // Channel 0 host read request
    typedef struct packed {
        logic                 valid;
        logic [addr_bits-1:0] addr;
        logic [tag_bits-1:0]  tag;
    } rd_req_t;

    // Channel 1 host write request
    typedef struct packed {
        logic                 valid;
        logic [addr_bits-1:0] addr;
        logic [tag_bits-1:0]  tag;
        logic [data_bits-1:0] data;
    } wr_req_t;

    // Host read response, returned in any order
    typedef struct packed {
        logic                 valid;
        logic [tag_bits-1:0]  tag;
        logic [data_bits-1:0] data;
    } rd_rsp_t;

    // Host write acknowledge
    typedef struct packed {
        logic                valid;
        logic [tag_bits-1:0] tag;
    } wr_rsp_t;

    // The user side sees its own label and never a host tag
    typedef struct packed {
        logic                 valid;
        logic [addr_bits-1:0] addr;
        logic [meta_bits-1:0] meta;
    } user_rd_req_t;

    typedef struct packed {
        logic                 valid;
        logic [addr_bits-1:0] addr;
        logic [meta_bits-1:0] meta;
        logic [data_bits-1:0] data;
    } user_wr_req_t;

    typedef struct packed {
        logic                 valid;
        logic [meta_bits-1:0] meta;
        logic [data_bits-1:0] data;
    } user_rd_rsp_t;

    typedef struct packed {
        logic                 valid;
        logic [meta_bits-1:0] meta;
    } user_wr_rsp_t;

    // Requests flow toward the host, the almost-full flags flow back up
    typedef struct packed {
        rd_req_t c0_req;
        wr_req_t c1_req;
        logic    c0_alm_full;
        logic    c1_alm_full;
    } host_tx_t;

    // Responses coming from the host
    typedef struct packed {
        rd_rsp_t c0_rsp;
        wr_rsp_t c1_rsp;
    } host_rx_t;

endpackage

//--- design/shim_buffer_host/shim_buffer_host.sv
//####################################################################
// Host-side buffer
// Registers every host response for one cycle on its way up so that
// a label lookup started on the raw response has its result ready.
// Requests pass down as wires or through one register stage
//####################################################################

`timescale 1ns/100ps

module shim_buffer_host
#(
    // Nonzero puts one register stage on the request path
    parameter int register_outbound = 0
)
(
    input  logic                   clk,
    input  logic                   rst_n,
    // Request fields are driven by the tracker and almost-full is driven here
    inout  wire mem_shim_pkg::host_tx_t tx_up,
    // Request fields are driven here and almost-full comes from the host
    inout  wire mem_shim_pkg::host_tx_t tx_host,
    input  mem_shim_pkg::host_rx_t rx_host,
    output mem_shim_pkg::host_rx_t rx_buf
);
    import mem_shim_pkg::*;

    generate
        if (register_outbound == 0)
        begin : g_wires
            // Straight through in both directions, zero cycles
            assign tx_host.c0_req = tx_up.c0_req;
            assign tx_host.c1_req = tx_up.c1_req;
            assign tx_up.c0_alm_full = tx_host.c0_alm_full;
            assign tx_up.c1_alm_full = tx_host.c1_alm_full;
        end
        else
        begin : g_regs
            rd_req_t c0_req_q;
            wr_req_t c1_req_q;
            logic    c0_alm_full_q;
            logic    c1_alm_full_q;

            // Almost-full takes the same one-cycle path as the requests,
            // so the host slack covers the extra stage
            always_ff @(posedge clk)
            begin
                c0_req_q      <= tx_up.c0_req;
                c1_req_q      <= tx_up.c1_req;
                c0_alm_full_q <= tx_host.c0_alm_full;
                c1_alm_full_q <= tx_host.c1_alm_full;
                if (!rst_n)
                begin
                    c0_req_q.valid <= 1'b0;
                    c1_req_q.valid <= 1'b0;
                end
            end

            assign tx_host.c0_req = c0_req_q;
            assign tx_host.c1_req = c1_req_q;
            assign tx_up.c0_alm_full = c0_alm_full_q;
            assign tx_up.c1_alm_full = c1_alm_full_q;
        end
    endgenerate

    // Responses always take exactly one cycle, with no back-pressure
    always_ff @(posedge clk)
    begin
        rx_buf <= rx_host;
        if (!rst_n)
        begin
            rx_buf.c0_rsp.valid <= 1'b0;
            rx_buf.c1_rsp.valid <= 1'b0;
        end
    end

endmodule

//--- design/req_meta_tracker/tag_free_list.sv
//####################################################################
// Tag free list
// Pool of free host tags for one channel. Offers the lowest free tag,
// takes allocations and releases in the same cycle and keeps a
// registered count of free tags
//####################################################################

`timescale 1ns/100ps

module tag_free_list
#(
    parameter int num_tags = 16
)
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                alloc,
    output logic [mem_shim_pkg::tag_bits-1:0]   alloc_tag,
    input  logic                                release_en,
    input  logic [mem_shim_pkg::tag_bits-1:0]   release_tag,
    output logic [$clog2(num_tags + 1)-1:0]     free_count
);
    import mem_shim_pkg::*;

    localparam int cnt_bits = $clog2(num_tags + 1);

    // One bit per tag, set while the tag is free
    logic [num_tags-1:0] free_vec;
    logic [num_tags-1:0] free_next;

    // Priority pick of the lowest free tag. Scanning downward lets the
    // last hit win, which is the lowest index
    always_comb
    begin
        alloc_tag = '0;
        for (int i = num_tags - 1; i >= 0; i--)
        begin
            if (free_vec[i])
            begin
                alloc_tag = tag_bits'(i);
            end
        end
    end

    // A released tag is outstanding, so it never equals the offered one
    always_comb
    begin
        free_next = free_vec;
        if (alloc)
        begin
            free_next[alloc_tag] = 1'b0;
        end
        if (release_en)
        begin
            free_next[release_tag] = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            // Every tag starts out free
            free_vec   <= '1;
            free_count <= cnt_bits'(num_tags);
        end
        else
        begin
            free_vec   <= free_next;
            free_count <= free_count + cnt_bits'(release_en) - cnt_bits'(alloc);
        end
    end

endmodule

//--- design/req_meta_tracker/meta_ram.sv
//####################################################################
// Label RAM
// Simple dual-port store of user labels indexed by host tag, with a
// one-cycle synchronous read
//####################################################################

`timescale 1ns/100ps

module meta_ram
#(
    parameter int num_tags = 16
)
(
    input  logic                               clk,
    input  logic                               wr_en,
    input  logic [mem_shim_pkg::tag_bits-1:0]  wr_tag,
    input  logic [mem_shim_pkg::meta_bits-1:0] wr_meta,
    input  logic [mem_shim_pkg::tag_bits-1:0]  rd_tag,
    output logic [mem_shim_pkg::meta_bits-1:0] rd_meta
);
    import mem_shim_pkg::*;

    // Maps to block RAM, so the contents carry no reset
    logic [meta_bits-1:0] mem [num_tags];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_tag] <= wr_meta;
        end
        // Read is started by the raw response tag and lands one cycle later
        rd_meta <= mem[rd_tag];
    end

endmodule

//--- design/req_meta_tracker/req_meta_tracker.sv
//####################################################################
// Request label tracker
// Swaps the user label for a host tag on each request, keeps the label
// in RAM under that tag and puts it back on the matching response.
// Also builds the almost-full seen by the user
//####################################################################

`timescale 1ns/100ps

module req_meta_tracker
#(
    parameter int num_tags = 16
)
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  mem_shim_pkg::user_rd_req_t user_rd_req,
    input  mem_shim_pkg::user_wr_req_t user_wr_req,
    output mem_shim_pkg::user_rd_rsp_t user_rd_rsp,
    output mem_shim_pkg::user_wr_rsp_t user_wr_rsp,
    output logic                       user_c0_alm_full,
    output logic                       user_c1_alm_full,
    // Requests are driven here and the host almost-full flags are read back
    inout  wire mem_shim_pkg::host_tx_t tx_up,
    input  mem_shim_pkg::host_rx_t     rx_early,
    input  mem_shim_pkg::host_rx_t     rx_buf
);
    import mem_shim_pkg::*;

    localparam int cnt_bits = $clog2(num_tags + 1);
    // Below this many free tags the user is told to hold off
    localparam int min_free_tags = 3;

    logic [tag_bits-1:0]  c0_alloc_tag;
    logic [tag_bits-1:0]  c1_alloc_tag;
    logic [cnt_bits-1:0]  c0_free_count;
    logic [cnt_bits-1:0]  c1_free_count;
    logic [meta_bits-1:0] c0_rd_meta;
    logic [meta_bits-1:0] c1_rd_meta;
    rd_req_t              c0_req;
    wr_req_t              c1_req;

    // Channel 0 reads. A tag goes back to the pool as the buffered
    // response leaves, and is free again on the following cycle
    tag_free_list #(.num_tags(num_tags)) c0_free_list_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc       (user_rd_req.valid),
        .alloc_tag   (c0_alloc_tag),
        .release_en  (rx_buf.c0_rsp.valid),
        .release_tag (rx_buf.c0_rsp.tag),
        .free_count  (c0_free_count)
    );

    meta_ram #(.num_tags(num_tags)) c0_meta_ram_i (
        .clk     (clk),
        .wr_en   (user_rd_req.valid),
        .wr_tag  (c0_alloc_tag),
        .wr_meta (user_rd_req.meta),
        .rd_tag  (rx_early.c0_rsp.tag),
        .rd_meta (c0_rd_meta)
    );

    // Channel 1 writes, same arrangement
    tag_free_list #(.num_tags(num_tags)) c1_free_list_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc       (user_wr_req.valid),
        .alloc_tag   (c1_alloc_tag),
        .release_en  (rx_buf.c1_rsp.valid),
        .release_tag (rx_buf.c1_rsp.tag),
        .free_count  (c1_free_count)
    );

    meta_ram #(.num_tags(num_tags)) c1_meta_ram_i (
        .clk     (clk),
        .wr_en   (user_wr_req.valid),
        .wr_tag  (c1_alloc_tag),
        .wr_meta (user_wr_req.meta),
        .rd_tag  (rx_early.c1_rsp.tag),
        .rd_meta (c1_rd_meta)
    );

    // Host requests go out in the same cycle, tag in place of the label
    always_comb
    begin
        c0_req.valid = user_rd_req.valid;
        c0_req.addr  = user_rd_req.addr;
        c0_req.tag   = c0_alloc_tag;

        c1_req.valid = user_wr_req.valid;
        c1_req.addr  = user_wr_req.addr;
        c1_req.tag   = c1_alloc_tag;
        c1_req.data  = user_wr_req.data;
    end

    assign tx_up.c0_req = c0_req;
    assign tx_up.c1_req = c1_req;

    // The RAM read started on rx_early finishes just as rx_buf shows up
    always_comb
    begin
        user_rd_rsp.valid = rx_buf.c0_rsp.valid;
        user_rd_rsp.meta  = c0_rd_meta;
        user_rd_rsp.data  = rx_buf.c0_rsp.data;

        user_wr_rsp.valid = rx_buf.c1_rsp.valid;
        user_wr_rsp.meta  = c1_rd_meta;
    end

    // The free counts are registered, so a request in this cycle cannot
    // feed back into the flag it is being checked against
    assign user_c0_alm_full = tx_up.c0_alm_full ||
                              (c0_free_count < cnt_bits'(min_free_tags));
    assign user_c1_alm_full = tx_up.c1_alm_full ||
                              (c1_free_count < cnt_bits'(min_free_tags));

endmodule

//--- design/mem_shim_top.sv
//####################################################################
// Memory shim top level
// Joins the label tracker to the host buffer. User ports on one side,
// host memory port on the other
//####################################################################

`timescale 1ns/100ps

module mem_shim_top
#(
    parameter int register_outbound = 0,
    parameter int num_tags          = 16
)
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  mem_shim_pkg::user_rd_req_t user_rd_req,
    input  mem_shim_pkg::user_wr_req_t user_wr_req,
    output mem_shim_pkg::user_rd_rsp_t user_rd_rsp,
    output mem_shim_pkg::user_wr_rsp_t user_wr_rsp,
    output logic                       user_c0_alm_full,
    output logic                       user_c1_alm_full,
    // Requests go out to the host and its almost-full flags come back in
    inout  wire mem_shim_pkg::host_tx_t tx_host,
    input  mem_shim_pkg::host_rx_t     rx_host
);
    import mem_shim_pkg::*;

    // Shared between tracker and buffer, driven from both ends by field
    wire host_tx_t tx_up;
    host_rx_t      rx_buf;

    // The raw host response also feeds the tracker so the label read
    // overlaps the buffer stage
    req_meta_tracker #(.num_tags(num_tags)) req_meta_tracker_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .user_rd_req      (user_rd_req),
        .user_wr_req      (user_wr_req),
        .user_rd_rsp      (user_rd_rsp),
        .user_wr_rsp      (user_wr_rsp),
        .user_c0_alm_full (user_c0_alm_full),
        .user_c1_alm_full (user_c1_alm_full),
        .tx_up            (tx_up),
        .rx_early         (rx_host),
        .rx_buf           (rx_buf)
    );

    shim_buffer_host #(.register_outbound(register_outbound)) shim_buffer_host_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .tx_up   (tx_up),
        .tx_host (tx_host),
        .rx_host (rx_host),
        .rx_buf  (rx_buf)
    );

endmodule

//--- testbench/host_mem_model.sv
//####################################################################
// Host memory model
// Sparse memory behind the host port. Holds each request for a random
// number of cycles and answers out of order, one response per channel
// per cycle. Flags a tag that arrives while it is still in use
//####################################################################

`timescale 1ns/100ps

module host_mem_model
#(
    // Request slots the host pretends to have per channel
    parameter int depth = 24
)
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  slow,
    input  mem_shim_pkg::rd_req_t c0_req,
    input  mem_shim_pkg::wr_req_t c1_req,
    output logic                  c0_alm_full,
    output logic                  c1_alm_full,
    output mem_shim_pkg::host_rx_t rx,
    output logic                  tag_clash
);
    import mem_shim_pkg::*;

    localparam int num_slots = 2 ** tag_bits;
    // Two slots of slack stay free after almost-full goes up
    localparam int alm_level = depth - 2;

    int seed = 73;
    int c0_count;
    int c1_count;
    int pick;
    rd_req_t c0_in;
    wr_req_t c1_in;

    // Only addresses that were written take up an entry
    logic [data_bits-1:0] mem [logic [addr_bits-1:0]];

    // Pending requests, one slot per tag
    logic                 c0_busy [num_slots];
    int                   c0_wait [num_slots];
    logic [data_bits-1:0] c0_data [num_slots];
    logic                 c1_busy [num_slots];
    int                   c1_wait [num_slots];

    // Unwritten words read back as a pattern built from the whole address
    function automatic logic [data_bits-1:0] read_word(input logic [addr_bits-1:0] addr);
        if (mem.exists(addr))
        begin
            return mem[addr];
        end
        return {~addr, addr};
    endfunction

    // A slow host adds a long fixed wait on top of the random one
    function automatic int pick_delay();
        int d;
        d = 1 + int'($unsigned($random(seed)) % 12);
        if (slow)
        begin
            d = d + 20;
        end
        return d;
    endfunction

    initial
    begin
        for (int t = 0; t < num_slots; t++)
        begin
            c0_busy[t] = 1'b0;
            c1_busy[t] = 1'b0;
            c0_wait[t] = 0;
            c1_wait[t] = 0;
            c0_data[t] = '0;
        end
        c0_count    = 0;
        c1_count    = 0;
        rx          = '0;
        tag_clash   = 1'b0;
        c0_alm_full = 1'b0;
        c1_alm_full = 1'b0;
    end

    always @(posedge clk)
    begin
        // Requests are taken as they stood at the edge
        c0_in = c0_req;
        c1_in = c1_req;
        #1;
        rx        = '0;
        tag_clash = 1'b0;
        if (rst_n)
        begin
            // Lowest ready tag answers first, random waits do the reordering
            pick = -1;
            for (int t = num_slots - 1; t >= 0; t--)
            begin
                if (c0_busy[t] && c0_wait[t] == 0)
                begin
                    pick = t;
                end
            end
            if (pick >= 0)
            begin
                rx.c0_rsp.valid = 1'b1;
                rx.c0_rsp.tag   = tag_bits'(pick);
                rx.c0_rsp.data  = c0_data[pick];
                c0_busy[pick]   = 1'b0;
                c0_count        = c0_count - 1;
            end

            pick = -1;
            for (int t = num_slots - 1; t >= 0; t--)
            begin
                if (c1_busy[t] && c1_wait[t] == 0)
                begin
                    pick = t;
                end
            end
            if (pick >= 0)
            begin
                rx.c1_rsp.valid = 1'b1;
                rx.c1_rsp.tag   = tag_bits'(pick);
                c1_busy[pick]   = 1'b0;
                c1_count        = c1_count - 1;
            end

            for (int t = 0; t < num_slots; t++)
            begin
                if (c0_busy[t] && c0_wait[t] > 0)
                begin
                    c0_wait[t] = c0_wait[t] - 1;
                end
                if (c1_busy[t] && c1_wait[t] > 0)
                begin
                    c1_wait[t] = c1_wait[t] - 1;
                end
            end

            // Read data is captured on arrival, so later writes cannot reach it
            if (c0_in.valid)
            begin
                tag_clash           = tag_clash | c0_busy[c0_in.tag];
                c0_busy[c0_in.tag]  = 1'b1;
                c0_wait[c0_in.tag]  = pick_delay();
                c0_data[c0_in.tag]  = read_word(c0_in.addr);
                c0_count            = c0_count + 1;
            end
            // Memory is written well before the acknowledge goes out
            if (c1_in.valid)
            begin
                tag_clash           = tag_clash | c1_busy[c1_in.tag];
                mem[c1_in.addr]     = c1_in.data;
                c1_busy[c1_in.tag]  = 1'b1;
                c1_wait[c1_in.tag]  = pick_delay();
                c1_count            = c1_count + 1;
            end
        end
        c0_alm_full = (c0_count >= alm_level);
        c1_alm_full = (c1_count >= alm_level);
    end

endmodule

//--- testbench/mem_shim_tb.sv
//####################################################################
// Memory shim testbench
// Random reads and writes over eight addresses against a host model
// that answers out of order, then a read burst against a slow host.
// Checks labels, data, timing and the almost-full flags
//####################################################################

`timescale 1ns/100ps

module mem_shim_tb;
    import mem_shim_pkg::*;

    localparam int num_tags     = 16;
    localparam int num_requests = 400;
    localparam int burst_len    = 20;
    localparam int cycle_limit  = num_requests * 16;
    // The user is held off once fewer than this many tags are free
    localparam int min_free_tags = 3;
    localparam logic [addr_bits-1:0] base_addr = 16'h0a40;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         slow;
    logic         tag_clash;
    logic         host_c0_alm_full;
    logic         host_c1_alm_full;
    logic         user_c0_alm_full;
    logic         user_c1_alm_full;
    user_rd_req_t user_rd_req;
    user_wr_req_t user_wr_req;
    user_rd_rsp_t user_rd_rsp;
    user_wr_rsp_t user_wr_rsp;
    wire host_tx_t tx_host;
    host_rx_t     rx_host;
    // Host response as it stood one edge earlier
    host_rx_t     rx_prev = '0;

    int seed = 73;
    int cycles = 0;
    int next_label = 0;
    int out_c0 = 0;
    int out_c1 = 0;
    logic saw_tag_alm = 1'b0;
    logic exp_c0_alm_full;
    logic exp_c1_alm_full;

    // Reference memory, updated when a write is issued
    logic [data_bits-1:0] ref_mem [8];
    int                   wr_pend [8];

    // Per label: channel, address slot, expected read data and state
    logic                 label_chan [num_requests];
    logic [2:0]           label_slot [num_requests];
    logic [data_bits-1:0] label_data [num_requests];
    logic                 label_open [num_requests];
    logic                 label_done [num_requests];

    always
    begin
        #10 clk = ~clk;
    end

    // The host drives the almost-full fields of the shared bundle
    assign tx_host.c0_alm_full = host_c0_alm_full;
    assign tx_host.c1_alm_full = host_c1_alm_full;

    mem_shim_top #(.register_outbound(0), .num_tags(num_tags)) mem_shim_top_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .user_rd_req      (user_rd_req),
        .user_wr_req      (user_wr_req),
        .user_rd_rsp      (user_rd_rsp),
        .user_wr_rsp      (user_wr_rsp),
        .user_c0_alm_full (user_c0_alm_full),
        .user_c1_alm_full (user_c1_alm_full),
        .tx_host          (tx_host),
        .rx_host          (rx_host)
    );

    host_mem_model host_mem_model_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .slow        (slow),
        .c0_req      (tx_host.c0_req),
        .c1_req      (tx_host.c1_req),
        .c0_alm_full (host_c0_alm_full),
        .c1_alm_full (host_c1_alm_full),
        .rx          (rx_host),
        .tag_clash   (tag_clash)
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input logic [63:0] expected,
                                   input logic [63:0] actual);
        stop_with_error($sformatf("Mismatch in %s: expected %0h, actual %0h",
                                  test, expected, actual));
    endtask

    // Advance to the drive point of the next cycle with nothing issued
    task automatic next_cycle();
        @(posedge clk);
        #2;
        user_rd_req.valid = 1'b0;
        user_wr_req.valid = 1'b0;
    endtask

    task automatic send_read(input logic [2:0] slot);
        user_rd_req.valid      = 1'b1;
        user_rd_req.addr       = base_addr + addr_bits'(slot);
        user_rd_req.meta       = meta_bits'(next_label);
        label_chan[next_label] = 1'b0;
        label_slot[next_label] = slot;
        label_data[next_label] = ref_mem[slot];
        label_open[next_label] = 1'b1;
        next_label++;
        out_c0++;
        assert (out_c0 <= num_tags)
            else stop_with_error("More reads are outstanding than there are tags");
    endtask

    task automatic send_write(input logic [2:0] slot, input logic [data_bits-1:0] data);
        user_wr_req.valid      = 1'b1;
        user_wr_req.addr       = base_addr + addr_bits'(slot);
        user_wr_req.meta       = meta_bits'(next_label);
        user_wr_req.data       = data;
        label_chan[next_label] = 1'b1;
        label_slot[next_label] = slot;
        label_open[next_label] = 1'b1;
        ref_mem[slot]          = data;
        wr_pend[slot]++;
        next_label++;
        out_c1++;
        assert (out_c1 <= num_tags)
            else stop_with_error("More writes are outstanding than there are tags");
    endtask

    // A label must be open on its own channel and is closed by its answer
    task automatic check_read_rsp(input logic [meta_bits-1:0] meta,
                                  input logic [data_bits-1:0] data);
        int lbl;
        lbl = int'(meta);
        assert (lbl < next_label && label_open[lbl] && label_chan[lbl] == 1'b0)
            else stop_with_error($sformatf(
                "Read response carried label %0d, which is not open on channel 0", lbl));
        assert (data == label_data[lbl])
            else report_mismatch("read data", label_data[lbl], data);
        label_open[lbl] = 1'b0;
        label_done[lbl] = 1'b1;
        out_c0--;
    endtask

    task automatic check_write_rsp(input logic [meta_bits-1:0] meta);
        int lbl;
        lbl = int'(meta);
        assert (lbl < next_label && label_open[lbl] && label_chan[lbl] == 1'b1)
            else stop_with_error($sformatf(
                "Write acknowledge carried label %0d, which is not open on channel 1", lbl));
        label_open[lbl] = 1'b0;
        label_done[lbl] = 1'b1;
        wr_pend[label_slot[lbl]]--;
        out_c1--;
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit)
        begin
            stop_with_error("The run hit its cycle limit before all requests finished");
        end
    end

    // Everything here is sampled at the edge, well away from the drive points
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            assert (!tag_clash)
                else stop_with_error("The host received a tag that was still in use");
            // Requests reach the host in the same cycle
            assert (tx_host.c0_req.valid == user_rd_req.valid)
                else report_mismatch("c0 request timing", user_rd_req.valid,
                                     tx_host.c0_req.valid);
            assert (!user_rd_req.valid || tx_host.c0_req.addr == user_rd_req.addr)
                else report_mismatch("c0 request addr", user_rd_req.addr, tx_host.c0_req.addr);
            assert (tx_host.c1_req.valid == user_wr_req.valid)
                else report_mismatch("c1 request timing", user_wr_req.valid,
                                     tx_host.c1_req.valid);
            assert (!user_wr_req.valid || tx_host.c1_req.data == user_wr_req.data)
                else report_mismatch("c1 request data", user_wr_req.data, tx_host.c1_req.data);
            // Free tags are the pool minus what is outstanding, except the
            // request at this edge which the registered count has not seen yet
            exp_c0_alm_full = host_c0_alm_full ||
                              (num_tags - out_c0 + int'(user_rd_req.valid) < min_free_tags);
            exp_c1_alm_full = host_c1_alm_full ||
                              (num_tags - out_c1 + int'(user_wr_req.valid) < min_free_tags);
            assert (user_c0_alm_full == exp_c0_alm_full)
                else report_mismatch("c0 almost-full", exp_c0_alm_full, user_c0_alm_full);
            assert (user_c1_alm_full == exp_c1_alm_full)
                else report_mismatch("c1 almost-full", exp_c1_alm_full, user_c1_alm_full);
            // Responses reach the user exactly one cycle after the host
            assert (user_rd_rsp.valid == rx_prev.c0_rsp.valid)
                else report_mismatch("c0 response timing", rx_prev.c0_rsp.valid,
                                     user_rd_rsp.valid);
            assert (user_wr_rsp.valid == rx_prev.c1_rsp.valid)
                else report_mismatch("c1 response timing", rx_prev.c1_rsp.valid,
                                     user_wr_rsp.valid);
            if (user_rd_rsp.valid)
            begin
                check_read_rsp(user_rd_rsp.meta, user_rd_rsp.data);
            end
            if (user_wr_rsp.valid)
            begin
                check_write_rsp(user_wr_rsp.meta);
            end
        end
        rx_prev = rx_host;
    end

    initial
    begin
        int r;
        int issued;
        int missing;
        logic [2:0] slot;
        logic [addr_bits-1:0] a;

        rst_n       = 1'b0;
        slow        = 1'b0;
        user_rd_req = '0;
        user_wr_req = '0;
        // Unwritten words hold a pattern of their full address
        for (int i = 0; i < 8; i++)
        begin
            a          = base_addr + addr_bits'(i);
            ref_mem[i] = {~a, a};
            wr_pend[i] = 0;
        end
        for (int i = 0; i < num_requests; i++)
        begin
            label_open[i] = 1'b0;
            label_done[i] = 1'b0;
        end

        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Nothing may be valid straight out of reset
        repeat (3)
        begin
            @(posedge clk);
            assert (!user_rd_rsp.valid && !user_wr_rsp.valid &&
                    !tx_host.c0_req.valid && !tx_host.c1_req.valid)
                else stop_with_error("A valid was high after reset with no stimulus");
        end
        #2;

        // Mixed traffic, one request per cycle at most.
        // A read waits until every write to its address has been acknowledged
        issued = 0;
        while (issued < num_requests - burst_len)
        begin
            next_cycle();
            r    = $random(seed);
            slot = r[2:0];
            if (r[3])
            begin
                if (!user_c1_alm_full)
                begin
                    send_write(slot, $random(seed));
                    issued++;
                end
            end
            else if (!user_c0_alm_full && wr_pend[slot] == 0)
            begin
                send_read(slot);
                issued++;
            end
        end
        next_cycle();
        wait (out_c0 == 0 && out_c1 == 0);

        // Slow host, so the tag pool runs low before the host fills up
        slow   = 1'b1;
        issued = 0;
        while (issued < burst_len)
        begin
            next_cycle();
            if (user_c0_alm_full && !tx_host.c0_alm_full)
            begin
                saw_tag_alm = 1'b1;
            end
            if (!user_c0_alm_full)
            begin
                send_read(issued[2:0]);
                issued++;
            end
        end
        next_cycle();
        slow = 1'b0;
        wait (out_c0 == 0);
        // Release, then the registered count, need a couple of cycles
        repeat (3) next_cycle();
        assert (saw_tag_alm)
            else stop_with_error("Channel 0 almost-full never rose from the tag pool");
        assert (!user_c0_alm_full)
            else stop_with_error("Channel 0 almost-full stayed high after the burst drained");

        missing = 0;
        for (int i = 0; i < next_label; i++)
        begin
            if (!label_done[i])
            begin
                missing++;
            end
        end
        if (missing == 0)
        begin
            $display("Test completed successfully");
            $finish;
        end
        else
        begin
            stop_with_error($sformatf("%0d labels never came back", missing));
        end
    end

endmodule

//--- mem_shim_top.f
common/mem_shim_pkg.sv
design/shim_buffer_host/shim_buffer_host.sv
design/req_meta_tracker/tag_free_list.sv
design/req_meta_tracker/meta_ram.sv
design/req_meta_tracker/req_meta_tracker.sv
design/mem_shim_top.sv
testbench/host_mem_model.sv
testbench/mem_shim_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the memory shim testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the run stops on $fatal.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_shim_tb -f mem_shim_top.f -o mem_shim_sim &&
./obj_dir/mem_shim_sim ||
exit 1
